// File: bench/ccis_shim_properties.sv
// CCI-S shim bound assertions
`timescale 1ns/1ps
`include "ccis_shim_consts.svh"

module ccis_shim_properties
(
    input logic                      clk,
    input logic                      reset,
    input logic                      c0_rsp_valid,
    input logic                      mmio_wr_valid,
    input logic                      mmio_rd_valid,
    input logic                      c1_rsp_valid,
    input ccis_shim_pkg::rsp_type_e  c1_rsp_type,
    input logic [`MDATA_W-1:0]       c1_rsp_mdata,
    input logic                      ccis_c0_rx_rd_valid,
    input logic                      ccis_c0_rx_wr_valid,
    input logic                      ccis_c1_rx_wr_valid,
    input logic [`MDATA_W-1:0]       ccis_c1_rx_mdata
);

    import ccis_shim_pkg::*;

    int fail_count = 0;

    // All response valids low in the first cycle out of reset
    reset_clears: assert property (@(posedge clk) $fell(reset) |->
        !c0_rsp_valid && !mmio_wr_valid && !mmio_rd_valid && !c1_rsp_valid)
    else
    begin
        $error("response valid high in the first cycle after reset");
        fail_count++;
    end

    // Host channel 1 response has priority and is one cycle late
    host_rsp_next: assert property (@(posedge clk) disable iff (reset)
        ccis_c1_rx_wr_valid |=> c1_rsp_valid && c1_rsp_type == RSP_WRLINE
        && c1_rsp_mdata == $past(ccis_c1_rx_mdata))
    else
    begin
        $error("host channel 1 write response not forwarded one cycle later");
        fail_count++;
    end

    // Channel 0 write responses never show up as read responses
    no_c0_write: assert property (@(posedge clk) disable iff (reset)
        (ccis_c0_rx_wr_valid && !ccis_c0_rx_rd_valid) |=> !c0_rsp_valid)
    else
    begin
        $error("channel 0 write response leaked onto c0_rsp_valid");
        fail_count++;
    end

    mmio_mutex: assert property (@(posedge clk) disable iff (reset)
        !(mmio_rd_valid && mmio_wr_valid))
    else
    begin
        $error("mmio read and write valid high together");
        fail_count++;
    end

endmodule

bind ccis_shim_top ccis_shim_properties props
(
    .clk                 (clk),
    .reset               (reset),
    .c0_rsp_valid        (c0_rsp_valid),
    .mmio_wr_valid       (mmio_wr_valid),
    .mmio_rd_valid       (mmio_rd_valid),
    .c1_rsp_valid        (c1_rsp_valid),
    .c1_rsp_type         (c1_rsp_type),
    .c1_rsp_mdata        (c1_rsp_mdata),
    .ccis_c0_rx_rd_valid (ccis_c0_rx_rd_valid),
    .ccis_c0_rx_wr_valid (ccis_c0_rx_wr_valid),
    .ccis_c1_rx_wr_valid (ccis_c1_rx_wr_valid),
    .ccis_c1_rx_mdata    (ccis_c1_rx_mdata)
);

// File: bench/ccis_shim_tb.sv
// CCI-S shim testbench
`timescale 1ns/1ps
`include "ccis_shim_consts.svh"

module ccis_shim_tb;

    import ccis_shim_pkg::*;

    localparam int PLANNED_CYCLES = 240;

    logic clk = 1'b0;
    logic reset = 1'b1;
    logic c0_req_valid, c1_req_valid, ccis_c0_alm_full, ccis_c1_alm_full;
    req_type_e c0_req_type, c1_req_type;
    logic [`ADDR_W-1:0] c0_req_addr, c1_req_addr, ccis_c0_tx_addr, ccis_c1_tx_addr;
    logic [`MDATA_W-1:0] c0_req_mdata, c1_req_mdata, ccis_c0_rx_mdata, ccis_c1_rx_mdata;
    logic [`MDATA_W-1:0] ccis_c0_tx_mdata, ccis_c1_tx_mdata, c0_rsp_mdata, mmio_addr, c1_rsp_mdata;
    logic [`DATA_W-1:0] c1_req_data, ccis_c0_rx_data, ccis_c1_tx_data, c0_rsp_data, mmio_data;
    logic ccis_c0_rx_rd_valid, ccis_c0_rx_wr_valid, ccis_c0_rx_csr_valid, ccis_c1_rx_wr_valid;
    logic c0_tx_alm_full, c1_tx_alm_full, ccis_c0_tx_valid, ccis_c1_tx_valid;
    logic c0_rsp_valid, mmio_wr_valid, mmio_rd_valid, c1_rsp_valid;
    ccis_req_e ccis_c0_tx_type, ccis_c1_tx_type;
    rsp_type_e c1_rsp_type;

    // Reference state, updated at the falling edge
    logic [31:0] lfsr = 32'h96655f8d;
    int errors = 0;
    int errors_base = 0;
    int cycles = 0;
    int pending = 0;
    int outstanding = 0;
    string test_name = "reset";
    logic checks_on = 1'b0;
    logic [`MDATA_W-1:0] wr_ref[$];
    logic [`MDATA_W-1:0] fence_ref[$];
    logic host_due, rd_due, csr_due, csr_is_rd, csr_data_ok, low_known;
    logic [`MDATA_W-1:0] host_mdata, rd_mdata, csr_addr;
    logic [`DATA_W-1:0] rd_data, csr_data;
    logic [`CSR_W-1:0] csr_low;

    ccis_shim_top uut (.*);

    always #2 clk = ~clk;

    // Galois LFSR, one step per bit taken
    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] r;
        r = '0;
        for (int i = 0; i < n; i++)
        begin
            r = {r[62:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
        end
        return r;
    endfunction

    // Host encoding a request type should get on a channel
    function automatic ccis_req_e expected_map(input logic chan1, input req_type_e t);
        case (t)
            REQ_RDLINE_I: return chan1 ? CREQ_NONE : CREQ_RDLINE_I;
            REQ_RDLINE_S: return chan1 ? CREQ_NONE : CREQ_RDLINE_S;
            REQ_WRLINE_I: return chan1 ? CREQ_WRLINE_I : CREQ_NONE;
            REQ_WRLINE_M: return chan1 ? CREQ_WRLINE_M : CREQ_NONE;
            REQ_WRFENCE:  return chan1 ? CREQ_WRFENCE : CREQ_NONE;
            default:      return CREQ_NONE;
        endcase
    endfunction

    task automatic check_val(input string what, input logic [63:0] exp, input logic [63:0] act);
        assert (exp === act)
        else
        begin
            $display("** Error %s %s: expected %h, actual %h", test_name, what, exp, act);
            errors++;
        end
    endtask

    task automatic check_true(input logic cond, input string msg);
        assert (cond)
        else
        begin
            $display("Test %s failed: %s", test_name, msg);
            errors++;
        end
    endtask

    task automatic start_test(input string name);
        test_name = name;
        errors_base = errors;
    endtask

    task automatic end_test();
        $display("%s finished with %0d errors", test_name, errors - errors_base);
    endtask

    task automatic clear_valids();
        c0_req_valid <= 1'b0;
        c1_req_valid <= 1'b0;
        ccis_c0_rx_rd_valid <= 1'b0;
        ccis_c0_rx_wr_valid <= 1'b0;
        ccis_c0_rx_csr_valid <= 1'b0;
        ccis_c1_rx_wr_valid <= 1'b0;
    endtask

    // ------------------------------
    // Reference model and checks
    // ------------------------------
    always @(negedge clk)
    begin
        if (reset)
        begin
            wr_ref.delete();
            fence_ref.delete();
            outstanding = 0;
            host_due = 1'b0;
            rd_due = 1'b0;
            csr_due = 1'b0;
            low_known = 1'b0;
        end
        else
        begin
            check_val("c0_tx_alm_full", ccis_c0_alm_full, c0_tx_alm_full);
            check_val("c1_tx_alm_full", ccis_c1_alm_full
                || fence_ref.size() >= `FENCE_DEPTH - `ALM_FULL_THRESH
                || outstanding >= `WR_RSP_DEPTH - `ALM_FULL_THRESH, c1_tx_alm_full);
            if (checks_on)
            begin
                check_val("c0 tx valid", c0_req_valid
                    && expected_map(1'b0, c0_req_type) != CREQ_NONE, ccis_c0_tx_valid);
                check_val("c1 tx valid", c1_req_valid
                    && expected_map(1'b1, c1_req_type) != CREQ_NONE, ccis_c1_tx_valid);
                if (ccis_c0_tx_valid)
                begin
                    check_val("c0 tx type", expected_map(1'b0, c0_req_type), ccis_c0_tx_type);
                    check_val("c0 tx addr", c0_req_addr, ccis_c0_tx_addr);
                    check_val("c0 tx mdata", c0_req_mdata, ccis_c0_tx_mdata);
                end
                if (ccis_c1_tx_valid)
                begin
                    check_val("c1 tx type", expected_map(1'b1, c1_req_type), ccis_c1_tx_type);
                    check_val("c1 tx addr", c1_req_addr, ccis_c1_tx_addr);
                    check_val("c1 tx mdata", c1_req_mdata, ccis_c1_tx_mdata);
                    check_val("c1 tx data", c1_req_data, ccis_c1_tx_data);
                end
            end
            // Read responses only, never a write
            check_val("c0_rsp_valid", rd_due, c0_rsp_valid);
            if (rd_due)
            begin
                check_val("c0_rsp_mdata", rd_mdata, c0_rsp_mdata);
                check_val("c0_rsp_data", rd_data, c0_rsp_data);
            end
            check_val("mmio_wr_valid", csr_due && !csr_is_rd, mmio_wr_valid);
            check_val("mmio_rd_valid", csr_due && csr_is_rd, mmio_rd_valid);
            if (csr_due)
                check_val("mmio_addr", csr_addr, mmio_addr);
            if (csr_due && !csr_is_rd && csr_data_ok)
                check_val("mmio_data", csr_data, mmio_data);
            // Channel 1 priority: host, queued writes, fences
            if (host_due || wr_ref.size() > 0)
            begin
                check_val("c1_rsp_valid", 1'b1, c1_rsp_valid);
                check_val("c1_rsp_type", RSP_WRLINE, c1_rsp_type);
                check_val("c1_rsp_mdata", host_due ? host_mdata : wr_ref.pop_front(),
                    c1_rsp_mdata);
                outstanding--;
            end
            else if (fence_ref.size() > 0)
            begin
                check_val("c1_rsp_valid", 1'b1, c1_rsp_valid);
                check_val("c1_rsp_type", RSP_WRFENCE, c1_rsp_type);
                check_val("c1_rsp_mdata", fence_ref.pop_front(), c1_rsp_mdata);
            end
            else
                check_val("c1_rsp_valid", 1'b0, c1_rsp_valid);

            // Inputs the DUT takes at the next rising edge
            host_due = ccis_c1_rx_wr_valid;
            host_mdata = ccis_c1_rx_mdata;
            rd_due = ccis_c0_rx_rd_valid;
            rd_mdata = ccis_c0_rx_mdata;
            rd_data = ccis_c0_rx_data;
            if (ccis_c0_rx_wr_valid)
                wr_ref.push_back(ccis_c0_rx_mdata);
            if (c1_req_valid && c1_req_type == REQ_WRFENCE)
                fence_ref.push_back(c1_req_mdata);
            if (c1_req_valid && (c1_req_type == REQ_WRLINE_I || c1_req_type == REQ_WRLINE_M))
                outstanding++;
            csr_due = ccis_c0_rx_csr_valid;
            if (csr_due)
            begin
                csr_is_rd = (ccis_c0_rx_mdata == `CSR_RD_COMPAT_ADDR);
                csr_addr = csr_is_rd ? ccis_c0_rx_data[`MDATA_W-1:0] : ccis_c0_rx_mdata;
                csr_data = {csr_low, ccis_c0_rx_data[`CSR_W-1:0]};
                csr_data_ok = low_known;
                csr_low = ccis_c0_rx_data[`CSR_W-1:0];
                low_known = 1'b1;
            end
        end
    end

    // ------------------------------
    // Stimulus
    // ------------------------------
    task automatic random_request(input logic chan1);
        logic [2:0] t;
        t = 3'(rand_bits(3) % 5);
        if (chan1)
        begin
            c1_req_type <= req_type_e'(t);
            c1_req_addr <= rand_bits(32);
            c1_req_mdata <= rand_bits(16);
            c1_req_data <= rand_bits(64);
            if (t == REQ_WRFENCE)
                c1_req_valid <= fence_ref.size() < 4;
            else if (t == REQ_WRLINE_I || t == REQ_WRLINE_M)
            begin
                c1_req_valid <= pending < 10;
                if (pending < 10)
                    pending++;
            end
            else
                c1_req_valid <= rand_bits(1);
        end
        else
        begin
            c0_req_valid <= rand_bits(1);
            c0_req_type <= req_type_e'(t);
            c0_req_addr <= rand_bits(32);
            c0_req_mdata <= rand_bits(16);
        end
    endtask

    // Answer every write still waiting on the host channel 1
    task automatic return_writes();
        while (pending > 0)
        begin
            @(posedge clk);
            clear_valids();
            ccis_c1_rx_wr_valid <= 1'b1;
            ccis_c1_rx_mdata <= rand_bits(16);
            pending--;
        end
        @(posedge clk);
        clear_valids();
    endtask

    task automatic wait_responses_drained();
        int n;
        n = 0;
        @(negedge clk);
        while ((c1_rsp_valid || wr_ref.size() > 0 || fence_ref.size() > 0) && n < 40)
        begin
            @(negedge clk);
            n++;
        end
        check_true(!c1_rsp_valid, "queued channel 1 responses never drained");
    endtask

    task automatic mixed_responses();
        logic [1:0] r;
        for (int i = 0; i < 60; i++)
        begin
            @(posedge clk);
            clear_valids();
            if (rand_bits(1))
                random_request(1'b1);
            r = rand_bits(2);
            ccis_c0_rx_mdata <= rand_bits(16);
            ccis_c0_rx_data <= rand_bits(64);
            ccis_c1_rx_mdata <= rand_bits(16);
            if (r == 2'd3)
                ccis_c0_rx_rd_valid <= 1'b1;
            else if (r != 2'd0 && pending > 0)
            begin
                ccis_c0_rx_wr_valid <= (r == 2'd1);
                ccis_c1_rx_wr_valid <= (r == 2'd2);
                pending--;
            end
        end
        return_writes();
        wait_responses_drained();
    endtask

    task automatic throttle_writes();
        int n;
        for (int i = 0; i < `WR_RSP_DEPTH - `ALM_FULL_THRESH; i++)
        begin
            @(posedge clk);
            clear_valids();
            c1_req_valid <= 1'b1;
            c1_req_type <= REQ_WRLINE_M;
            c1_req_mdata <= rand_bits(16);
            pending++;
        end
        @(posedge clk);
        clear_valids();
        n = 0;
        while (!c1_tx_alm_full && n < 4)
        begin
            @(negedge clk);
            n++;
        end
        check_true(c1_tx_alm_full, "c1_tx_alm_full did not rise after the write burst");
        n = 0;
        while (c1_tx_alm_full && n < 8)
        begin
            @(posedge clk);
            clear_valids();
            ccis_c1_rx_wr_valid <= 1'b1;
            ccis_c1_rx_mdata <= rand_bits(16);
            pending--;
            @(negedge clk);
            n++;
        end
        check_true(!c1_tx_alm_full, "c1_tx_alm_full stayed high as responses returned");
        return_writes();
        wait_responses_drained();
    endtask

    initial
    begin
        clear_valids();
        ccis_c0_alm_full = 1'b0;
        ccis_c1_alm_full = 1'b0;
        c0_req_type = REQ_RDLINE_I;
        c1_req_type = REQ_WRLINE_I;
        {c0_req_addr, c1_req_addr, c0_req_mdata, c1_req_mdata} = '0;
        {c1_req_data, ccis_c0_rx_data, ccis_c0_rx_mdata, ccis_c1_rx_mdata} = '0;
        repeat (10) @(posedge clk);
        reset <= 1'b0;
        start_test("reset");
        @(negedge clk);
        check_val("response valids", 4'b0,
            {c0_rsp_valid, mmio_wr_valid, mmio_rd_valid, c1_rsp_valid});
        @(posedge clk);
        checks_on = 1'b1;
        end_test();

        start_test("request_mapping");
        for (int i = 0; i < 48; i++)
        begin
            @(posedge clk);
            clear_valids();
            random_request(1'b0);
            random_request(1'b1);
            ccis_c0_alm_full <= rand_bits(1);
            ccis_c1_alm_full <= rand_bits(1);
        end
        @(posedge clk);
        clear_valids();
        ccis_c0_alm_full <= 1'b0;
        ccis_c1_alm_full <= 1'b0;
        return_writes();
        wait_responses_drained();
        end_test();

        start_test("c1_responses");
        mixed_responses();
        end_test();

        start_test("csr_mapping");
        for (int i = 0; i < 6; i++)
        begin
            @(posedge clk);
            clear_valids();
            ccis_c0_rx_csr_valid <= 1'b1;
            ccis_c0_rx_mdata <= (i == 4) ? `CSR_RD_COMPAT_ADDR : {4'h1, 12'(rand_bits(12))};
            ccis_c0_rx_data <= rand_bits(64);
        end
        @(posedge clk);
        clear_valids();
        repeat (3) @(posedge clk);
        end_test();

        start_test("throttling");
        throttle_writes();
        end_test();

        repeat (4) @(posedge clk);
        $display("Summary: %0d check errors, %0d property failures",
            errors, uut.props.fail_count);
        if (errors == 0 && uut.props.fail_count == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

    // Run limit
    always @(posedge clk)
    begin
        cycles++;
        if (cycles > 8 * PLANNED_CYCLES)
        begin
            $display("Timeout: run went past %0d cycles", 8 * PLANNED_CYCLES);
            $display("=== FAIL ===");
            $finish;
        end
    end

endmodule

// File: files.f
+incdir+verilog
verilog/ccis_shim_pkg.sv
verilog/mdata_fifo.sv
verilog/tx_translate.sv
verilog/rx_c0_map.sv
verilog/c1_rsp_merge.sv
verilog/ccis_shim_top.sv
bench/ccis_shim_properties.sv
bench/ccis_shim_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the shim testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f files.f \
    --top-module ccis_shim_tb -o ccis_shim_sim || exit 1
./obj_dir/ccis_shim_sim +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log
grep -q "=== FAIL ===" sim.log && exit 1
grep -q "=== PASS ===" sim.log || exit 1
exit 0

// File: verilog/c1_rsp_merge.sv
// Channel 1 response merger
`timescale 1ns/1ps
`include "ccis_shim_consts.svh"

module c1_rsp_merge
(
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      ccis_c1_rx_wr_valid,
    input  logic [`MDATA_W-1:0]       ccis_c1_rx_mdata,
    input  logic                      wr_issued,
    input  logic [`MDATA_W-1:0]       wr_head_mdata,
    input  logic                      wr_not_empty,
    input  logic [`MDATA_W-1:0]       fence_head_mdata,
    input  logic                      fence_not_empty,
    output logic                      wr_pop,
    output logic                      fence_pop,
    output logic                      c1_rsp_valid,
    output ccis_shim_pkg::rsp_type_e  c1_rsp_type,
    output logic [`MDATA_W-1:0]       c1_rsp_mdata,
    output logic                      writes_alm_full
);

    import ccis_shim_pkg::*;

    localparam int CNT_W = $clog2(`WR_RSP_DEPTH + 1);
    localparam logic [CNT_W-1:0] WR_ALM_LEVEL = CNT_W'(`WR_RSP_DEPTH - `ALM_FULL_THRESH);

    logic                host_valid;
    logic [`MDATA_W-1:0] host_mdata;
    logic [CNT_W-1:0]    wr_count;
    logic                wr_done;

    // Registered host response
    always_ff @(posedge clk)
    begin
        if (reset)
            host_valid <= 1'b0;
        else
            host_valid <= ccis_c1_rx_wr_valid;
        host_mdata <= ccis_c1_rx_mdata;
    end

    // Host first, then queued write responses, then fences
    assign wr_pop       = !host_valid && wr_not_empty;
    assign fence_pop    = !host_valid && !wr_not_empty && fence_not_empty;
    assign c1_rsp_valid = host_valid || wr_not_empty || fence_not_empty;
    assign c1_rsp_type  = fence_pop ? RSP_WRFENCE : RSP_WRLINE;
    assign c1_rsp_mdata = host_valid ? host_mdata :
                          (wr_not_empty ? wr_head_mdata : fence_head_mdata);

    // Outstanding writes, both edges may land in one cycle
    assign wr_done = c1_rsp_valid && (c1_rsp_type == RSP_WRLINE);

    always_ff @(posedge clk)
    begin
        if (reset)
            wr_count <= '0;
        else if (wr_issued && !wr_done)
            wr_count <= wr_count + CNT_W'(1);
        else if (!wr_issued && wr_done)
            wr_count <= wr_count - CNT_W'(1);
    end

    assign writes_alm_full = (wr_count >= WR_ALM_LEVEL);

endmodule

// File: verilog/ccis_shim_consts.svh
// CCI-S shim constants
`ifndef CCIS_SHIM_CONSTS_SVH
`define CCIS_SHIM_CONSTS_SVH

// ------------------------------
// Widths
// ------------------------------

// Host line address
`define ADDR_W 32
// Request tag carried through to the response
`define MDATA_W 16
// Narrowed cache line payload
`define DATA_W 64
// Native CSR write width on the host link
`define CSR_W 32

// ------------------------------
// Queue sizing and flow control
// ------------------------------

// Write response queue, also the cap on outstanding writes
`define WR_RSP_DEPTH 16
`define FENCE_DEPTH 8
// Requests the accelerator may still issue once almost-full rises
`define ALM_FULL_THRESH 2

// CSR write to this address is turned into a CSR read
`define CSR_RD_COMPAT_ADDR 16'h0FF0

`endif

// File: verilog/ccis_shim_pkg.sv
// CCI-S shim types
package ccis_shim_pkg;

    // ------------------------------
    // Accelerator side
    // ------------------------------

    // Request type as issued by the accelerator on either channel
    typedef enum logic [2:0]
    {
        REQ_RDLINE_I,
        REQ_RDLINE_S,
        REQ_WRLINE_I,
        REQ_WRLINE_M,
        REQ_WRFENCE
    } req_type_e;

    // Channel 1 response type seen by the accelerator
    typedef enum logic [1:0]
    {
        RSP_WRLINE,
        RSP_WRFENCE
    } rsp_type_e;

    // ------------------------------
    // Host side
    // ------------------------------

    // Host request header encoding, NONE marks a suppressed request
    typedef enum logic [3:0]
    {
        CREQ_NONE = 4'd0,
        CREQ_RDLINE_I,
        CREQ_RDLINE_S,
        CREQ_WRLINE_I,
        CREQ_WRLINE_M,
        CREQ_WRFENCE
    } ccis_req_e;

endpackage

// File: verilog/ccis_shim_top.sv
// CCI-S host link shim
`timescale 1ns/1ps
`include "ccis_shim_consts.svh"

module ccis_shim_top
(
    input  logic                      clk,
    input  logic                      reset,

    // Accelerator requests
    input  logic                      c0_req_valid,
    input  ccis_shim_pkg::req_type_e  c0_req_type,
    input  logic [`ADDR_W-1:0]        c0_req_addr,
    input  logic [`MDATA_W-1:0]       c0_req_mdata,
    input  logic                      c1_req_valid,
    input  ccis_shim_pkg::req_type_e  c1_req_type,
    input  logic [`ADDR_W-1:0]        c1_req_addr,
    input  logic [`MDATA_W-1:0]       c1_req_mdata,
    input  logic [`DATA_W-1:0]        c1_req_data,
    output logic                      c0_tx_alm_full,
    output logic                      c1_tx_alm_full,

    // Host requests
    output logic                      ccis_c0_tx_valid,
    output ccis_shim_pkg::ccis_req_e  ccis_c0_tx_type,
    output logic [`ADDR_W-1:0]        ccis_c0_tx_addr,
    output logic [`MDATA_W-1:0]       ccis_c0_tx_mdata,
    output logic                      ccis_c1_tx_valid,
    output ccis_shim_pkg::ccis_req_e  ccis_c1_tx_type,
    output logic [`ADDR_W-1:0]        ccis_c1_tx_addr,
    output logic [`MDATA_W-1:0]       ccis_c1_tx_mdata,
    output logic [`DATA_W-1:0]        ccis_c1_tx_data,
    input  logic                      ccis_c0_alm_full,
    input  logic                      ccis_c1_alm_full,

    // Host responses
    input  logic                      ccis_c0_rx_rd_valid,
    input  logic                      ccis_c0_rx_wr_valid,
    input  logic                      ccis_c0_rx_csr_valid,
    input  logic [`MDATA_W-1:0]       ccis_c0_rx_mdata,
    input  logic [`DATA_W-1:0]        ccis_c0_rx_data,
    input  logic                      ccis_c1_rx_wr_valid,
    input  logic [`MDATA_W-1:0]       ccis_c1_rx_mdata,

    // Accelerator responses and MMIO
    output logic                      c0_rsp_valid,
    output logic [`MDATA_W-1:0]       c0_rsp_mdata,
    output logic [`DATA_W-1:0]        c0_rsp_data,
    output logic                      mmio_wr_valid,
    output logic                      mmio_rd_valid,
    output logic [`MDATA_W-1:0]       mmio_addr,
    output logic [`DATA_W-1:0]        mmio_data,
    output logic                      c1_rsp_valid,
    output ccis_shim_pkg::rsp_type_e  c1_rsp_type,
    output logic [`MDATA_W-1:0]       c1_rsp_mdata
);

    logic                wr_issued;
    logic                fence_issued;
    logic                fence_alm_full;
    logic                writes_alm_full;
    logic                wr_pop;
    logic                fence_pop;
    logic [`MDATA_W-1:0] wr_head_mdata;
    logic [`MDATA_W-1:0] fence_head_mdata;
    logic                wr_not_empty;
    logic                fence_not_empty;

    tx_translate u_tx (.*);

    rx_c0_map u_rx_c0 (.*);

    // Channel 0 write responses waiting to move to channel 1
    mdata_fifo #(.DEPTH(`WR_RSP_DEPTH), .ALM_THRESH(`ALM_FULL_THRESH)) wr_rsp_q
    (
        .clk        (clk),
        .reset      (reset),
        .push       (ccis_c0_rx_wr_valid),
        .push_mdata (ccis_c0_rx_mdata),
        .pop        (wr_pop),
        .head_mdata (wr_head_mdata),
        .not_empty  (wr_not_empty),
        .alm_full   ()
    );

    // Issued fences awaiting their synthesized response
    mdata_fifo #(.DEPTH(`FENCE_DEPTH), .ALM_THRESH(`ALM_FULL_THRESH)) fence_q
    (
        .clk        (clk),
        .reset      (reset),
        .push       (fence_issued),
        .push_mdata (c1_req_mdata),
        .pop        (fence_pop),
        .head_mdata (fence_head_mdata),
        .not_empty  (fence_not_empty),
        .alm_full   (fence_alm_full)
    );

    c1_rsp_merge u_merge (.*);

endmodule

// File: verilog/mdata_fifo.sv
// Request tag FIFO
`timescale 1ns/1ps
`include "ccis_shim_consts.svh"

module mdata_fifo
#(
    parameter int DEPTH      = 16,
    parameter int ALM_THRESH = 2
)
(
    input  logic                clk,
    input  logic                reset,
    input  logic                push,
    input  logic [`MDATA_W-1:0] push_mdata,
    input  logic                pop,
    output logic [`MDATA_W-1:0] head_mdata,
    output logic                not_empty,
    output logic                alm_full
);

    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);
    localparam logic [CNT_W-1:0] ALM_LEVEL = CNT_W'(DEPTH - ALM_THRESH);

    logic [`MDATA_W-1:0] mem [DEPTH];
    logic [PTR_W-1:0]    wr_ptr;
    logic [PTR_W-1:0]    rd_ptr;
    logic [CNT_W-1:0]    count;
    logic                full;
    logic                do_push;
    logic                do_pop;

    assign full       = (count == CNT_W'(DEPTH));
    assign do_push    = push && !full;
    assign do_pop     = pop && not_empty;
    assign not_empty  = (count != '0);
    assign alm_full   = (count >= ALM_LEVEL);
    assign head_mdata = mem[rd_ptr];

    // Storage
    always_ff @(posedge clk)
    begin
        if (do_push)
            mem[wr_ptr] <= push_mdata;
    end

    // Pointers and occupancy
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (do_push)
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + PTR_W'(1);
            if (do_pop)
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + PTR_W'(1);
            case ({do_push, do_pop})
                2'b10:   count <= count + CNT_W'(1);
                2'b01:   count <= count - CNT_W'(1);
                default: count <= count;
            endcase
        end
    end

endmodule

// File: verilog/rx_c0_map.sv
// Channel 0 receive mapping
`timescale 1ns/1ps
`include "ccis_shim_consts.svh"

module rx_c0_map
(
    input  logic                clk,
    input  logic                reset,

    input  logic                ccis_c0_rx_rd_valid,
    input  logic                ccis_c0_rx_csr_valid,
    input  logic [`MDATA_W-1:0] ccis_c0_rx_mdata,
    input  logic [`DATA_W-1:0]  ccis_c0_rx_data,

    output logic                c0_rsp_valid,
    output logic [`MDATA_W-1:0] c0_rsp_mdata,
    output logic [`DATA_W-1:0]  c0_rsp_data,
    output logic                mmio_wr_valid,
    output logic                mmio_rd_valid,
    output logic [`MDATA_W-1:0] mmio_addr,
    output logic [`DATA_W-1:0]  mmio_data
);

    // Low word of the last CSR write, becomes the next write's high half
    logic [`CSR_W-1:0] csr_low_prev;
    logic              csr_is_rd;

    // Compatibility mode read, the CSR address sits in the data
    assign csr_is_rd = (ccis_c0_rx_mdata == `CSR_RD_COMPAT_ADDR);

    // ------------------------------
    // Control
    // ------------------------------
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            c0_rsp_valid  <= 1'b0;
            mmio_wr_valid <= 1'b0;
            mmio_rd_valid <= 1'b0;
        end
        else
        begin
            c0_rsp_valid  <= ccis_c0_rx_rd_valid;
            mmio_wr_valid <= ccis_c0_rx_csr_valid && !csr_is_rd;
            mmio_rd_valid <= ccis_c0_rx_csr_valid && csr_is_rd;
        end
    end

    // ------------------------------
    // Payload
    // ------------------------------
    always_ff @(posedge clk)
    begin
        c0_rsp_mdata <= ccis_c0_rx_mdata;
        c0_rsp_data  <= ccis_c0_rx_data;

        if (ccis_c0_rx_csr_valid)
        begin
            csr_low_prev <= ccis_c0_rx_data[`CSR_W-1:0];
            mmio_data    <= {csr_low_prev, ccis_c0_rx_data[`CSR_W-1:0]};
            if (csr_is_rd)
                mmio_addr <= ccis_c0_rx_data[`MDATA_W-1:0];
            else
                mmio_addr <= ccis_c0_rx_mdata;
        end
    end

endmodule

// File: verilog/tx_translate.sv
// Request header translation
`timescale 1ns/1ps
`include "ccis_shim_consts.svh"

module tx_translate
(
    input  logic                      clk,
    input  logic                      reset,

    input  logic                      c0_req_valid,
    input  ccis_shim_pkg::req_type_e  c0_req_type,
    input  logic [`ADDR_W-1:0]        c0_req_addr,
    input  logic [`MDATA_W-1:0]       c0_req_mdata,
    input  logic                      c1_req_valid,
    input  ccis_shim_pkg::req_type_e  c1_req_type,
    input  logic [`ADDR_W-1:0]        c1_req_addr,
    input  logic [`MDATA_W-1:0]       c1_req_mdata,
    input  logic [`DATA_W-1:0]        c1_req_data,

    input  logic                      ccis_c0_alm_full,
    input  logic                      ccis_c1_alm_full,
    input  logic                      fence_alm_full,
    input  logic                      writes_alm_full,

    output logic                      ccis_c0_tx_valid,
    output ccis_shim_pkg::ccis_req_e  ccis_c0_tx_type,
    output logic [`ADDR_W-1:0]        ccis_c0_tx_addr,
    output logic [`MDATA_W-1:0]       ccis_c0_tx_mdata,
    output logic                      ccis_c1_tx_valid,
    output ccis_shim_pkg::ccis_req_e  ccis_c1_tx_type,
    output logic [`ADDR_W-1:0]        ccis_c1_tx_addr,
    output logic [`MDATA_W-1:0]       ccis_c1_tx_mdata,
    output logic [`DATA_W-1:0]        ccis_c1_tx_data,

    output logic                      c0_tx_alm_full,
    output logic                      c1_tx_alm_full,
    output logic                      wr_issued,
    output logic                      fence_issued
);

    import ccis_shim_pkg::*;

    ccis_req_e c0_map;
    ccis_req_e c1_map;
    logic      gate_open;

    // Requests pass only once the shim has left reset
    always_ff @(posedge clk)
    begin
        if (reset)
            gate_open <= 1'b0;
        else
            gate_open <= 1'b1;
    end

    // Channel 0 carries reads only
    always_comb
    begin
        case (c0_req_type)
            REQ_RDLINE_I: c0_map = CREQ_RDLINE_I;
            REQ_RDLINE_S: c0_map = CREQ_RDLINE_S;
            default:      c0_map = CREQ_NONE;
        endcase
    end

    // Channel 1 carries writes and fences
    always_comb
    begin
        case (c1_req_type)
            REQ_WRLINE_I: c1_map = CREQ_WRLINE_I;
            REQ_WRLINE_M: c1_map = CREQ_WRLINE_M;
            REQ_WRFENCE:  c1_map = CREQ_WRFENCE;
            default:      c1_map = CREQ_NONE;
        endcase
    end

    assign ccis_c0_tx_valid = gate_open && c0_req_valid && (c0_map != CREQ_NONE);
    assign ccis_c0_tx_type  = c0_map;
    assign ccis_c0_tx_addr  = c0_req_addr;
    assign ccis_c0_tx_mdata = c0_req_mdata;

    assign ccis_c1_tx_valid = gate_open && c1_req_valid && (c1_map != CREQ_NONE);
    assign ccis_c1_tx_type  = c1_map;
    assign ccis_c1_tx_addr  = c1_req_addr;
    assign ccis_c1_tx_mdata = c1_req_mdata;
    assign ccis_c1_tx_data  = c1_req_data;

    // Issue strobes feed the fence queue and the outstanding write count
    assign fence_issued = ccis_c1_tx_valid && (c1_map == CREQ_WRFENCE);
    assign wr_issued    = ccis_c1_tx_valid && (c1_map != CREQ_WRFENCE);

    assign c0_tx_alm_full = ccis_c0_alm_full;
    assign c1_tx_alm_full = ccis_c1_alm_full || fence_alm_full || writes_alm_full;

endmodule
